/* hw/addr_gen_pkg.sv */
package addr_gen_pkg;

    localparam int NUM_BANKS = 36;
    localparam int A_WID     = 8;   // bank address width
    localparam int L_WID     = 10;  // line address width
    localparam int RUN_BIT   = 2;   // run flag inside the controller state

    localparam logic [A_WID-1:0] STEP      = 8'd37;
    localparam logic [L_WID-1:0] LINE_LAST = 10'd767;

    // which offset byte an access uses, idle means no access this cycle
    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_A    = 2'd1,  // low byte
        PH_B    = 2'd2,  // middle byte
        PH_C    = 2'd3   // high byte
    } phase_e;

    // read phase sits in the upper half, as on the controller bus
    typedef struct packed {
        phase_e rd_phase;
        phase_e wr_phase;
    } cycle_t;

    typedef struct packed {
        logic [A_WID-1:0] hi;
        logic [A_WID-1:0] mid;
        logic [A_WID-1:0] lo;
    } bank_offset_t;

    // shared feed from the base sequencer into every bank cell
    typedef struct packed {
        logic [A_WID-1:0] rd_base;
        logic [A_WID-1:0] wr_base;
        logic             rd_en;
        logic             wr_en;
    } base_t;

    typedef struct packed {
        logic [A_WID-1:0] addr;
        logic             wr;
    } wr_port_t;

    // per-bank skew, the first eight banks run unshifted
    localparam bank_offset_t BANK_OFFSETS [NUM_BANKS] = '{
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd255, 8'd0},
        '{8'd0,   8'd129, 8'd65},
        '{8'd0,   8'd224, 8'd240},
        '{8'd0,   8'd216, 8'd236},
        '{8'd0,   8'd157, 8'd250},
        '{8'd0,   8'd132, 8'd242},
        '{8'd0,   8'd184, 8'd247},
        '{8'd0,   8'd254, 8'd240},
        '{8'd0,   8'd115, 8'd242},
        '{8'd0,   8'd209, 8'd164},
        '{8'd0,   8'd255, 8'd248},
        '{8'd0,   8'd246, 8'd58},
        '{8'd0,   8'd253, 8'd215},
        '{8'd0,   8'd252, 8'd209},
        '{8'd0,   8'd146, 8'd249},
        '{8'd0,   8'd231, 8'd250},
        '{8'd254, 8'd200, 8'd0},   // only bank with a nonzero high byte
        '{8'd0,   8'd85,  8'd235},
        '{8'd0,   8'd229, 8'd69},
        '{8'd0,   8'd203, 8'd254},
        '{8'd0,   8'd131, 8'd251},
        '{8'd0,   8'd115, 8'd254},
        '{8'd0,   8'd253, 8'd255},
        '{8'd0,   8'd248, 8'd254},
        '{8'd0,   8'd255, 8'd243},
        '{8'd0,   8'd239, 8'd253},
        '{8'd0,   8'd248, 8'd215},
        '{8'd0,   8'd252, 8'd164}
    };

endpackage

/* hw/base_sequencer.sv */
`timescale 1ns/1ps

module base_sequencer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [3:0]           fsm,
    input  addr_gen_pkg::cycle_t cycle,
    input  logic                 rd_step,
    input  logic                 wr_step,
    output addr_gen_pkg::base_t  base
);

    logic                           run;
    logic [addr_gen_pkg::A_WID-1:0] rd_base_q;
    logic [addr_gen_pkg::A_WID-1:0] wr_base_q;

    assign run = fsm[addr_gen_pkg::RUN_BIT];

    // both bases restart from zero whenever the controller leaves run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_base_q <= '0;
            wr_base_q <= '0;
        end else if (!run) begin
            rd_base_q <= '0;
            wr_base_q <= '0;
        end else begin
            if (rd_step) begin
                rd_base_q <= rd_base_q + addr_gen_pkg::STEP;  // wraps modulo 256
            end
            if (wr_step) begin
                wr_base_q <= wr_base_q + addr_gen_pkg::STEP;
            end
        end
    end

    assign base.rd_base = rd_base_q;
    assign base.wr_base = wr_base_q;

    // enables are decoded once here and fanned out to all banks
    assign base.rd_en = run & (cycle.rd_phase != addr_gen_pkg::PH_IDLE);
    assign base.wr_en = run & (cycle.wr_phase != addr_gen_pkg::PH_IDLE);

endmodule

/* hw/bank_addr_cell.sv */
`timescale 1ns/1ps

module bank_addr_cell (
    input  logic                       clk,
    input  logic                       reset_n,
    input  addr_gen_pkg::base_t        base,
    input  addr_gen_pkg::cycle_t       cycle,
    input  addr_gen_pkg::bank_offset_t offset,
    input  logic                       sync_bit,
    output logic [addr_gen_pkg::A_WID-1:0] rd_addr,
    output addr_gen_pkg::wr_port_t     wr_port
);

    logic [addr_gen_pkg::A_WID-1:0] rd_off;
    logic [addr_gen_pkg::A_WID-1:0] wr_off;
    logic [addr_gen_pkg::A_WID-1:0] rd_addr_q;
    logic [addr_gen_pkg::A_WID-1:0] wr_addr_q;
    logic                           wr_q;

    // idle never reaches the registers since the enable is low then
    function automatic logic [addr_gen_pkg::A_WID-1:0] pick_byte(
        input addr_gen_pkg::phase_e       ph,
        input addr_gen_pkg::bank_offset_t off
    );
        case (ph)
            addr_gen_pkg::PH_A: pick_byte = off.lo;
            addr_gen_pkg::PH_B: pick_byte = off.mid;
            addr_gen_pkg::PH_C: pick_byte = off.hi;
            default:            pick_byte = '0;
        endcase
    endfunction

    assign rd_off = pick_byte(cycle.rd_phase, offset);
    assign wr_off = pick_byte(cycle.wr_phase, offset);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr_q <= '0;
        end else if (base.rd_en) begin
            rd_addr_q <= base.rd_base + rd_off;  // address holds between accesses
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_q <= '0;
        end else if (base.wr_en) begin
            wr_addr_q <= base.wr_base + wr_off;
        end
    end

    // a bank only writes when its sync input agrees with the shared enable
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= base.wr_en & sync_bit;
        end
    end

    assign rd_addr      = rd_addr_q;
    assign wr_port.addr = wr_addr_q;
    assign wr_port.wr   = wr_q;

endmodule

/* hw/line_counter.sv */
`timescale 1ns/1ps

module line_counter (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           step,
    output logic [addr_gen_pkg::L_WID-1:0] line_addr
);

    logic [addr_gen_pkg::L_WID-1:0] line_q;

    // counts over the 768 lines of one direction and wraps back to 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line_q <= '0;
        end else if (step) begin
            if (line_q == addr_gen_pkg::LINE_LAST) begin
                line_q <= '0;
            end else begin
                line_q <= line_q + 1'b1;
            end
        end
    end

    assign line_addr = line_q;

endmodule

/* hw/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic [3:0]                            fsm,
    input  addr_gen_pkg::cycle_t                  cycle,
    input  logic                                  rd_step,
    input  logic                                  wr_step,
    input  logic                                  rd_line_step,
    input  logic                                  wr_line_step,
    input  logic [addr_gen_pkg::NUM_BANKS-1:0]    sync_in,
    output logic [addr_gen_pkg::NUM_BANKS-1:0][addr_gen_pkg::A_WID-1:0] rd_addr,
    output addr_gen_pkg::wr_port_t [addr_gen_pkg::NUM_BANKS-1:0]        wr_port,
    output logic [addr_gen_pkg::L_WID-1:0]        rd_line,
    output logic [addr_gen_pkg::L_WID-1:0]        wr_line
);

    addr_gen_pkg::base_t base;  // one feed shared by every bank

    base_sequencer u_seq (
        .clk     (clk),
        .reset_n (reset_n),
        .fsm     (fsm),
        .cycle   (cycle),
        .rd_step (rd_step),
        .wr_step (wr_step),
        .base    (base)
    );

    // each bank differs only in its table entry and sync bit
    for (genvar i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin : g_bank
        bank_addr_cell u_cell (
            .clk      (clk),
            .reset_n  (reset_n),
            .base     (base),
            .cycle    (cycle),
            .offset   (addr_gen_pkg::BANK_OFFSETS[i]),
            .sync_bit (sync_in[i]),
            .rd_addr  (rd_addr[i]),
            .wr_port  (wr_port[i])
        );
    end

    line_counter u_rd_line (
        .clk       (clk),
        .reset_n   (reset_n),
        .step      (rd_line_step),
        .line_addr (rd_line)
    );

    line_counter u_wr_line (
        .clk       (clk),
        .reset_n   (reset_n),
        .step      (wr_line_step),
        .line_addr (wr_line)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period of 2 ns gives the 4 ns clock
    always #2 clk = ~clk;

endmodule

/* tests/addr_gen_assert.sv */
`timescale 1ns/1ps

module addr_gen_assert (
    input logic                                  clk,
    input logic                                  reset_n,
    input logic [3:0]                            fsm,
    input addr_gen_pkg::cycle_t                  cycle,
    input logic [addr_gen_pkg::NUM_BANKS-1:0]    sync_in,
    input logic [addr_gen_pkg::NUM_BANKS-1:0][addr_gen_pkg::A_WID-1:0] rd_addr,
    input addr_gen_pkg::wr_port_t [addr_gen_pkg::NUM_BANKS-1:0]        wr_port
);

    int unsigned                        fail_count = 0;
    logic [addr_gen_pkg::NUM_BANKS-1:0] strobes;
    logic                               rd_en;
    logic                               wr_en;

    always_comb begin
        for (int i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin
            strobes[i] = wr_port[i].wr;
        end
    end

    // an access happens only in run with a phase other than idle
    assign rd_en = fsm[addr_gen_pkg::RUN_BIT] && (cycle.rd_phase != addr_gen_pkg::PH_IDLE);
    assign wr_en = fsm[addr_gen_pkg::RUN_BIT] && (cycle.wr_phase != addr_gen_pkg::PH_IDLE);

    a_reset_quiet: assert property (@(posedge clk)
        (!reset_n || $rose(reset_n)) |-> (strobes == '0))
        else begin
            fail_count++;
            $error("write strobe high during or right after reset");
        end

    for (genvar i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin : g_bank
        // a strobe needs run, a write phase and this bank's sync one edge earlier
        a_strobe_cause: assert property (@(posedge clk) disable iff (!reset_n)
            wr_port[i].wr |-> $past(wr_en && sync_in[i]))
            else begin
                fail_count++;
                $error("bank %0d write strobe without a qualified write", i);
            end

        a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
            !rd_en |=> $stable(rd_addr[i]))
            else begin
                fail_count++;
                $error("bank %0d read address moved without a read", i);
            end

        a_wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
            !wr_en |=> $stable(wr_port[i].addr))
            else begin
                fail_count++;
                $error("bank %0d write address moved without a write", i);
            end
    end

endmodule

/* tests/addr_gen_tb.sv */
`timescale 1ns/1ps

module addr_gen_tb;

    localparam int CYCLE_LIMIT = 4000;  // about twice the length of all tests

    logic                                  clk;
    logic                                  reset_n;
    logic [3:0]                            fsm;
    addr_gen_pkg::cycle_t                  cycle;
    logic                                  rd_step;
    logic                                  wr_step;
    logic                                  rd_line_step;
    logic                                  wr_line_step;
    logic [addr_gen_pkg::NUM_BANKS-1:0]    sync_in;
    logic [addr_gen_pkg::NUM_BANKS-1:0][addr_gen_pkg::A_WID-1:0] rd_addr;
    addr_gen_pkg::wr_port_t [addr_gen_pkg::NUM_BANKS-1:0]        wr_port;
    logic [addr_gen_pkg::L_WID-1:0]        rd_line;
    logic [addr_gen_pkg::L_WID-1:0]        wr_line;

    // reference model state
    logic [addr_gen_pkg::A_WID-1:0] m_rd_base;
    logic [addr_gen_pkg::A_WID-1:0] m_wr_base;
    logic [addr_gen_pkg::A_WID-1:0] m_rd_addr [addr_gen_pkg::NUM_BANKS];
    logic [addr_gen_pkg::A_WID-1:0] m_wr_addr [addr_gen_pkg::NUM_BANKS];
    logic                           m_wr      [addr_gen_pkg::NUM_BANKS];
    logic [addr_gen_pkg::L_WID-1:0] m_rd_line;
    logic [addr_gen_pkg::L_WID-1:0] m_wr_line;

    string       test_name = "none";
    int unsigned cycles = 0;

    tb_clock u_clock (.clk(clk));

    addr_gen u_addr_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .fsm          (fsm),
        .cycle        (cycle),
        .rd_step      (rd_step),
        .wr_step      (wr_step),
        .rd_line_step (rd_line_step),
        .wr_line_step (wr_line_step),
        .sync_in      (sync_in),
        .rd_addr      (rd_addr),
        .wr_port      (wr_port),
        .rd_line      (rd_line),
        .wr_line      (wr_line)
    );

    bind addr_gen addr_gen_assert u_assert (
        .clk     (clk),
        .reset_n (reset_n),
        .fsm     (fsm),
        .cycle   (cycle),
        .sync_in (sync_in),
        .rd_addr (rd_addr),
        .wr_port (wr_port)
    );

    function automatic logic [addr_gen_pkg::A_WID-1:0] offset_byte(
        input int                   bank,
        input addr_gen_pkg::phase_e ph
    );
        case (ph)
            addr_gen_pkg::PH_A: return addr_gen_pkg::BANK_OFFSETS[bank].lo;
            addr_gen_pkg::PH_B: return addr_gen_pkg::BANK_OFFSETS[bank].mid;
            addr_gen_pkg::PH_C: return addr_gen_pkg::BANK_OFFSETS[bank].hi;
            default:            return '0;
        endcase
    endfunction

    function automatic logic [addr_gen_pkg::NUM_BANKS-1:0] random_sync();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[addr_gen_pkg::NUM_BANKS-1:0];
    endfunction

    task automatic report_mismatch(input string what, input int exp, input int act);
        $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic model_reset();
        m_rd_base = '0;
        m_wr_base = '0;
        m_rd_line = '0;
        m_wr_line = '0;
        for (int i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin
            m_rd_addr[i] = '0;
            m_wr_addr[i] = '0;
            m_wr[i]      = 1'b0;
        end
    endtask

    // one rising edge of the model, using the inputs the DUT just sampled
    task automatic model_edge();
        logic run;
        logic rd_en;
        logic wr_en;
        run   = fsm[addr_gen_pkg::RUN_BIT];
        rd_en = run && (cycle.rd_phase != addr_gen_pkg::PH_IDLE);
        wr_en = run && (cycle.wr_phase != addr_gen_pkg::PH_IDLE);
        for (int i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin
            if (rd_en) m_rd_addr[i] = m_rd_base + offset_byte(i, cycle.rd_phase);
            if (wr_en) m_wr_addr[i] = m_wr_base + offset_byte(i, cycle.wr_phase);
            m_wr[i] = wr_en && sync_in[i];
        end
        if (!run) begin
            m_rd_base = '0;
            m_wr_base = '0;
        end else begin
            if (rd_step) m_rd_base = m_rd_base + addr_gen_pkg::STEP;
            if (wr_step) m_wr_base = m_wr_base + addr_gen_pkg::STEP;
        end
        if (rd_line_step) m_rd_line = (m_rd_line == addr_gen_pkg::LINE_LAST) ? '0 : m_rd_line + 1;
        if (wr_line_step) m_wr_line = (m_wr_line == addr_gen_pkg::LINE_LAST) ? '0 : m_wr_line + 1;
    endtask

    task automatic check_outputs();
        for (int i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin
            assert (rd_addr[i] == m_rd_addr[i])
                else report_mismatch($sformatf("bank %0d rd_addr", i), m_rd_addr[i], rd_addr[i]);
            assert (wr_port[i].addr == m_wr_addr[i])
                else report_mismatch($sformatf("bank %0d wr addr", i), m_wr_addr[i],
                                     wr_port[i].addr);
            assert (wr_port[i].wr == m_wr[i])
                else report_mismatch($sformatf("bank %0d wr strobe", i), m_wr[i], wr_port[i].wr);
        end
        assert (rd_line == m_rd_line) else report_mismatch("rd_line", m_rd_line, rd_line);
        assert (wr_line == m_wr_line) else report_mismatch("wr_line", m_wr_line, wr_line);
    endtask

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic tick();
        @(posedge clk);
        model_edge();
        #1;
        check_outputs();
    endtask

    task automatic randomize_access();
        cycle.rd_phase = addr_gen_pkg::phase_e'($urandom_range(0, 3));
        cycle.wr_phase = addr_gen_pkg::phase_e'($urandom_range(0, 3));
        rd_step        = $urandom_range(0, 1);
        wr_step        = $urandom_range(0, 1);
        sync_in        = random_sync();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end else if (u_addr_gen.u_assert.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        void'($urandom(59507));
        reset_n      = 1'b0;
        fsm          = '0;
        cycle        = '0;
        rd_step      = 1'b0;
        wr_step      = 1'b0;
        rd_line_step = 1'b0;
        wr_line_step = 1'b0;
        sync_in      = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        reset_n   = 1'b1;
        test_name = "reset";
        check_outputs();

        // lines start from 0 here and 769 strobes land on 1 after the wrap
        test_name    = "line_wrap";
        fsm          = 4'b0100;
        rd_line_step = 1'b1;
        wr_line_step = 1'b1;
        for (int n = 0; n < 769; n++) begin
            randomize_access();
            tick();
        end
        rd_line_step = 1'b0;
        wr_line_step = 1'b0;
        assert (rd_line == 10'd1) else report_mismatch("rd_line after wrap", 1, rd_line);
        assert (wr_line == 10'd1) else report_mismatch("wr_line after wrap", 1, wr_line);

        for (int p = 1; p < 4; p++) begin
            test_name      = $sformatf("read_phase_%0d", p);
            cycle.rd_phase = addr_gen_pkg::phase_e'(p);
            cycle.wr_phase = addr_gen_pkg::PH_IDLE;
            for (int n = 0; n < 40; n++) begin
                rd_step = $urandom_range(0, 1);
                tick();
            end
        end

        test_name = "write_sync";
        rd_step   = 1'b0;
        for (int n = 0; n < 120; n++) begin
            cycle.rd_phase = addr_gen_pkg::PH_IDLE;
            cycle.wr_phase = addr_gen_pkg::phase_e'($urandom_range(0, 3));
            wr_step        = $urandom_range(0, 1);
            sync_in        = random_sync();
            tick();
        end

        test_name = "hold_idle";
        cycle     = '0;
        for (int n = 0; n < 10; n++) begin
            rd_step = $urandom_range(0, 1);
            wr_step = $urandom_range(0, 1);
            tick();
        end

        test_name = "run_clear";
        fsm       = 4'b0000;
        tick();
        fsm            = 4'b0100;
        rd_step        = 1'b0;
        wr_step        = 1'b0;
        cycle.rd_phase = addr_gen_pkg::PH_A;
        cycle.wr_phase = addr_gen_pkg::PH_B;
        tick();
        for (int i = 0; i < addr_gen_pkg::NUM_BANKS; i++) begin
            assert (rd_addr[i] == addr_gen_pkg::BANK_OFFSETS[i].lo)
                else report_mismatch($sformatf("bank %0d rd_addr from base 0", i),
                                     addr_gen_pkg::BANK_OFFSETS[i].lo, rd_addr[i]);
        end

        test_name = "random_mix";
        for (int n = 0; n < 800; n++) begin
            fsm = 4'($urandom());
            if ($urandom_range(0, 7) != 0) fsm[addr_gen_pkg::RUN_BIT] = 1'b1;  // mostly in run
            randomize_access();
            rd_line_step = $urandom_range(0, 1);
            wr_line_step = $urandom_range(0, 1);
            tick();
        end

        test_name = "drain";
        fsm       = '0;
        cycle     = '0;
        repeat (3) tick();

        if (u_addr_gen.u_assert.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", u_addr_gen.u_assert.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
    end

endmodule

/* filelist.f */
hw/addr_gen_pkg.sv
hw/base_sequencer.sv
hw/bank_addr_cell.sv
hw/line_counter.sv
hw/addr_gen.sv
tests/tb_clock.sv
tests/addr_gen_assert.sv
tests/addr_gen_tb.sv
